/* include/mrpw_macros.svh */
`ifndef MRPW_MACROS_SVH
`define MRPW_MACROS_SVH

`define MRPW_WIDTH      16  // data bits per word
`define MRPW_NUMWRPT    2   // write ports
`define MRPW_NUMRDPT    2   // read ports and replicas

`define MRPW_NUMVBNK    4
`define MRPW_BITVBNK    2   // log2 of banks
`define MRPW_NUMVROW    16  // rows per bank
`define MRPW_BITVROW    4

`define MRPW_SRAM_DELAY 2   // bank read latency in cycles

`endif

/* list.f */
+incdir+include
logic/mrpw_pkg.sv
logic/mrpw_ctrl.sv
logic/mrpw_bank_map.sv
logic/mrpw_sram_1r1w.sv
logic/mrpw_top.sv
sim/mrpw_chk.sv
sim/mrpw_tb.sv

/* logic/mrpw_bank_map.sv */
`timescale 1ns/10ps
`include "mrpw_macros.svh"

module mrpw_bank_map (
  input  logic                    clk,
  input  logic                    rst_n,
  input  mrpw_pkg::wr_req_t       wr_q     [`MRPW_NUMWRPT],
  input  mrpw_pkg::rd_req_t       rd_q     [`MRPW_NUMRDPT],
  input  mrpw_pkg::mem_wr_t       init_wr,
  output mrpw_pkg::mem_wr_t       mem_wr   [`MRPW_NUMVBNK],
  output mrpw_pkg::mem_rd_t       mem_rd   [`MRPW_NUMRDPT][`MRPW_NUMVBNK],
  input  logic [`MRPW_WIDTH-1:0]  mem_dout [`MRPW_NUMRDPT][`MRPW_NUMVBNK],
  output mrpw_pkg::rd_rsp_t       rd_rsp   [`MRPW_NUMRDPT]
);

  logic [`MRPW_NUMWRPT-1:0]     wr_hit   [`MRPW_NUMVBNK];  // port p addresses bank b
  logic [`MRPW_SRAM_DELAY-1:0]  vld_pipe [`MRPW_NUMRDPT];
  logic [`MRPW_BITVBNK-1:0]     bnk_pipe [`MRPW_NUMRDPT][`MRPW_SRAM_DELAY];

  always_comb begin
    for (int b = 0; b < `MRPW_NUMVBNK; b++) begin
      for (int p = 0; p < `MRPW_NUMWRPT; p++) begin
        wr_hit[b][p] = wr_q[p].write && (wr_q[p].badr == `MRPW_BITVBNK'(b));
      end
    end
  end

  // lowest port wins each bank
  always_comb begin
    for (int b = 0; b < `MRPW_NUMVBNK; b++) begin
      mem_wr[b] = '0;
      if (init_wr.we) begin
        mem_wr[b] = init_wr;
      end else begin
        for (int p = `MRPW_NUMWRPT - 1; p >= 0; p--) begin
          if (wr_hit[b][p]) begin
            mem_wr[b].we   = 1'b1;
            mem_wr[b].addr = wr_q[p].radr;
            mem_wr[b].din  = wr_q[p].din;
          end
        end
      end
    end
  end

  // read port p only uses replica p
  always_comb begin
    for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
      for (int b = 0; b < `MRPW_NUMVBNK; b++) begin
        mem_rd[p][b].re   = rd_q[p].read && (rd_q[p].badr == `MRPW_BITVBNK'(b));
        mem_rd[p][b].addr = rd_q[p].radr;
      end
    end
  end

  // valid and bank select follow the sram latency
  always_ff @(posedge clk) begin
    for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
      vld_pipe[p][0] <= rd_q[p].read;
      bnk_pipe[p][0] <= rd_q[p].badr;
      for (int s = 1; s < `MRPW_SRAM_DELAY; s++) begin
        vld_pipe[p][s] <= vld_pipe[p][s-1];
        bnk_pipe[p][s] <= bnk_pipe[p][s-1];
      end
    end
    if (!rst_n) begin
      for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
        vld_pipe[p] <= '0;
      end
    end
  end

  always_comb begin
    for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
      rd_rsp[p].vld = vld_pipe[p][`MRPW_SRAM_DELAY-1];
      if (rd_rsp[p].vld) begin
        rd_rsp[p].dout = mem_dout[p][bnk_pipe[p][`MRPW_SRAM_DELAY-1]];
      end else begin
        rd_rsp[p].dout = '0;
      end
    end
  end

endmodule

/* logic/mrpw_ctrl.sv */
`timescale 1ns/10ps
`include "mrpw_macros.svh"

module mrpw_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  mrpw_pkg::wr_req_t  wr_req [`MRPW_NUMWRPT],
  input  mrpw_pkg::rd_req_t  rd_req [`MRPW_NUMRDPT],
  output mrpw_pkg::wr_req_t  wr_q   [`MRPW_NUMWRPT],
  output mrpw_pkg::rd_req_t  rd_q   [`MRPW_NUMRDPT],
  output mrpw_pkg::mem_wr_t  init_wr,
  output logic               ready
);

  import mrpw_pkg::*;

  ctrl_state_t               state;
  ctrl_state_t               state_nxt;
  logic [`MRPW_BITVROW-1:0]  row;
  logic [`MRPW_BITVROW-1:0]  row_nxt;
  logic                      last_row;
  logic                      accept;

  assign last_row = (row == `MRPW_BITVROW'(`MRPW_NUMVROW - 1));
  assign accept   = (state == st_run);  // strobes pass only once running

  // next state and sweep row
  always_comb begin
    state_nxt = state;
    row_nxt   = row;
    case (state)
      st_init: begin
        row_nxt = row + 1'b1;
        if (last_row) begin
          state_nxt = st_run;
        end
      end
      st_run: begin
        row_nxt = '0;
      end
      default: begin
        state_nxt = st_init;
        row_nxt   = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_init;
      row   <= '0;
      ready <= 1'b0;
    end else begin
      state <= state_nxt;
      row   <= row_nxt;
      ready <= (state_nxt == st_run);  // mirrors the run state
    end
  end

  // every bank takes the same row at once
  always_comb begin
    init_wr.we   = (state == st_init);
    init_wr.addr = row;
    init_wr.din  = '0;
  end

  // input register with strobes masked until running
  always_ff @(posedge clk) begin
    for (int p = 0; p < `MRPW_NUMWRPT; p++) begin
      wr_q[p]       <= wr_req[p];
      wr_q[p].write <= wr_req[p].write && accept;
    end
    for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
      rd_q[p]      <= rd_req[p];
      rd_q[p].read <= rd_req[p].read && accept;
    end
    if (!rst_n) begin
      for (int p = 0; p < `MRPW_NUMWRPT; p++) begin
        wr_q[p].write <= 1'b0;
      end
      for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
        rd_q[p].read <= 1'b0;
      end
    end
  end

endmodule

/* logic/mrpw_pkg.sv */
`include "mrpw_macros.svh"

package mrpw_pkg;

  // request from one write port
  typedef struct packed {
    logic                     write;
    logic [`MRPW_BITVBNK-1:0] badr;
    logic [`MRPW_BITVROW-1:0] radr;
    logic [`MRPW_WIDTH-1:0]   din;
  } wr_req_t;

  typedef struct packed {
    logic                     read;
    logic [`MRPW_BITVBNK-1:0] badr;
    logic [`MRPW_BITVROW-1:0] radr;
  } rd_req_t;

  typedef struct packed {
    logic                   vld;
    logic [`MRPW_WIDTH-1:0] dout;  // zero when vld low
  } rd_rsp_t;

  // one write command, shared by every replica of a bank
  typedef struct packed {
    logic                     we;
    logic [`MRPW_BITVROW-1:0] addr;
    logic [`MRPW_WIDTH-1:0]   din;
  } mem_wr_t;

  typedef struct packed {
    logic                     re;
    logic [`MRPW_BITVROW-1:0] addr;
  } mem_rd_t;

  typedef enum logic {
    st_init,  // clearing rows after reset
    st_run
  } ctrl_state_t;

endpackage

/* logic/mrpw_sram_1r1w.sv */
`timescale 1ns/10ps

module mrpw_sram_1r1w #(
  parameter int WIDTH   = 16,
  parameter int BITADDR = 4,
  parameter int NUMADDR = 16,
  parameter int DELAY   = 2   // at least 1
) (
  input  logic               clk,
  input  logic               we,
  input  logic [BITADDR-1:0] waddr,
  input  logic [WIDTH-1:0]   din,
  input  logic               re,
  input  logic [BITADDR-1:0] raddr,
  output logic [WIDTH-1:0]   dout
);

  logic [WIDTH-1:0] mem     [NUMADDR];
  logic [WIDTH-1:0] rd_pipe [DELAY];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= din;
    end
  end

  // same-edge write returns old data
  always_ff @(posedge clk) begin
    if (re) begin
      rd_pipe[0] <= mem[raddr];
    end
    for (int s = 1; s < DELAY; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign dout = rd_pipe[DELAY-1];

endmodule

/* logic/mrpw_top.sv */
`timescale 1ns/10ps
`include "mrpw_macros.svh"

module mrpw_top (
  input  logic               clk,
  input  logic               rst_n,
  input  mrpw_pkg::wr_req_t  wr_req [`MRPW_NUMWRPT],
  input  mrpw_pkg::rd_req_t  rd_req [`MRPW_NUMRDPT],
  output mrpw_pkg::rd_rsp_t  rd_rsp [`MRPW_NUMRDPT],
  output logic               ready
);

  import mrpw_pkg::*;

  wr_req_t                  wr_q     [`MRPW_NUMWRPT];
  rd_req_t                  rd_q     [`MRPW_NUMRDPT];
  mem_wr_t                  init_wr;
  mem_wr_t                  mem_wr   [`MRPW_NUMVBNK];
  mem_rd_t                  mem_rd   [`MRPW_NUMRDPT][`MRPW_NUMVBNK];
  logic [`MRPW_WIDTH-1:0]   mem_dout [`MRPW_NUMRDPT][`MRPW_NUMVBNK];

  mrpw_ctrl u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .wr_q    (wr_q),
    .rd_q    (rd_q),
    .init_wr (init_wr),
    .ready   (ready)
  );

  mrpw_bank_map u_bank_map (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_q     (wr_q),
    .rd_q     (rd_q),
    .init_wr  (init_wr),
    .mem_wr   (mem_wr),
    .mem_rd   (mem_rd),
    .mem_dout (mem_dout),
    .rd_rsp   (rd_rsp)
  );

  // one full set of banks per read port
  for (genvar p = 0; p < `MRPW_NUMRDPT; p++) begin : g_rep
    for (genvar b = 0; b < `MRPW_NUMVBNK; b++) begin : g_bnk
      mrpw_sram_1r1w #(
        .WIDTH   (`MRPW_WIDTH),
        .BITADDR (`MRPW_BITVROW),
        .NUMADDR (`MRPW_NUMVROW),
        .DELAY   (`MRPW_SRAM_DELAY)
      ) u_sram (
        .clk   (clk),
        .we    (mem_wr[b].we),
        .waddr (mem_wr[b].addr),
        .din   (mem_wr[b].din),
        .re    (mem_rd[p][b].re),
        .raddr (mem_rd[p][b].addr),
        .dout  (mem_dout[p][b])
      );
    end
  end

endmodule

/* sim/mrpw_chk.sv */
`timescale 1ns/10ps
`include "mrpw_macros.svh"

module mrpw_chk (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ready,
  input  mrpw_pkg::rd_req_t  rd_req [`MRPW_NUMRDPT],
  input  mrpw_pkg::rd_rsp_t  rd_rsp [`MRPW_NUMRDPT]
);

  localparam int LAT = 1 + `MRPW_SRAM_DELAY;  // edge of request to edge of response

  logic [`MRPW_NUMRDPT-1:0] acc;  // reads the input register will take
  logic [`MRPW_NUMRDPT-1:0] vld;
  int                       assert_errs = 0;

  always_comb begin
    for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
      acc[p] = rd_req[p].read && ready;
      vld[p] = rd_rsp[p].vld;
    end
  end

  a_ready_holds: assert property (@(posedge clk) disable iff (!rst_n) ready |=> ready)
    else begin
      assert_errs = assert_errs + 1;
      $error("ready fell after it had risen");
    end

  a_no_vld_early: assert property (@(posedge clk) disable iff (!rst_n) !ready |-> (vld == '0))
    else begin
      assert_errs = assert_errs + 1;
      $error("read valid seen while ready is low");
    end

  // each accepted read answers LAT edges later
  a_vld_count: assert property (@(posedge clk) disable iff (!rst_n)
      $countones(vld) == $past($countones(acc), LAT))
    else begin
      assert_errs = assert_errs + 1;
      $error("read valid count does not match accepted reads");
    end

endmodule

bind mrpw_top mrpw_chk u_chk (
  .clk    (clk),
  .rst_n  (rst_n),
  .ready  (ready),
  .rd_req (rd_req),
  .rd_rsp (rd_rsp)
);

/* sim/mrpw_tb.sv */
`timescale 1ns/10ps
`include "mrpw_macros.svh"

module mrpw_tb;

  import mrpw_pkg::*;

  localparam int DEPTH       = 1 + `MRPW_SRAM_DELAY;  // cycles from read to response
  localparam int NUM_TESTS   = 6;
  localparam int RAND_CYC    = 400;
  localparam int TIMEOUT_CYC = 5 + `MRPW_NUMVROW + NUM_TESTS * RAND_CYC + 20;

  logic     clk;
  logic     rst_n;
  wr_req_t  wr_req [`MRPW_NUMWRPT];
  rd_req_t  rd_req [`MRPW_NUMRDPT];
  rd_rsp_t  rd_rsp [`MRPW_NUMRDPT];
  logic     ready;

  wr_req_t                 stim_wr [`MRPW_NUMWRPT];  // applied on the next cycle
  rd_req_t                 stim_rd [`MRPW_NUMRDPT];
  logic [`MRPW_WIDTH-1:0]  shadow  [`MRPW_NUMVBNK][`MRPW_NUMVROW];
  logic [`MRPW_WIDTH:0]    exp_q   [`MRPW_NUMRDPT][$];  // {vld, dout} per port
  logic [31:0]             lfsr    = 32'h983c289f;
  int                      cyc_run = 0;  // cycles since reset release
  int                      tick_cnt = 0;

  mrpw_top u_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp),
    .ready  (ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    tick_cnt <= tick_cnt + 1;
    if (tick_cnt >= TIMEOUT_CYC) begin
      $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYC);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hd0000001;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic set_idle();
    for (int p = 0; p < `MRPW_NUMWRPT; p++) begin
      stim_wr[p] = '0;
    end
    for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
      stim_rd[p] = '0;
    end
  endtask

  task automatic set_write(input int p, input int bnk, input int row,
                           input logic [31:0] d);
    stim_wr[p].write = 1'b1;
    stim_wr[p].badr  = `MRPW_BITVBNK'(bnk);
    stim_wr[p].radr  = `MRPW_BITVROW'(row);
    stim_wr[p].din   = d[`MRPW_WIDTH-1:0];
  endtask

  task automatic set_read(input int p, input int bnk, input int row);
    stim_rd[p].read = 1'b1;
    stim_rd[p].badr = `MRPW_BITVBNK'(bnk);
    stim_rd[p].radr = `MRPW_BITVROW'(row);
  endtask

  task automatic random_stim(input logic rd_always, input logic wr_always);
    for (int p = 0; p < `MRPW_NUMWRPT; p++) begin
      stim_wr[p].write = 1'(take_bits(1)) | wr_always;
      stim_wr[p].badr  = `MRPW_BITVBNK'(take_bits(`MRPW_BITVBNK));
      stim_wr[p].radr  = `MRPW_BITVROW'(take_bits(`MRPW_BITVROW));
      stim_wr[p].din   = `MRPW_WIDTH'(take_bits(`MRPW_WIDTH));
    end
    for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
      stim_rd[p].read = 1'(take_bits(1)) | rd_always;
      stim_rd[p].badr = `MRPW_BITVBNK'(take_bits(`MRPW_BITVBNK));
      stim_rd[p].radr = `MRPW_BITVROW'(take_bits(`MRPW_BITVROW));
    end
  endtask

  // check this cycle's outputs, then drive and model the stimulus
  task automatic run_cycle();
    logic [`MRPW_WIDTH:0]   exp;
    logic [`MRPW_WIDTH:0]   got;
    logic                   exp_ready;
    logic [`MRPW_NUMVBNK-1:0] taken;
    @(posedge clk);
    #5;
    cyc_run++;
    exp_ready = (cyc_run >= `MRPW_NUMVROW);
    check_eq("ready", exp_ready, ready);
    check_eq("checker assertion failures", 0, u_dut.u_chk.assert_errs);
    for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
      exp = exp_q[p].pop_front();
      got = {rd_rsp[p].vld, rd_rsp[p].dout};
      check_eq($sformatf("rd_rsp[%0d]", p), exp, got);
    end
    for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
      if (exp_ready && stim_rd[p].read) begin
        exp_q[p].push_back({1'b1, shadow[stim_rd[p].badr][stim_rd[p].radr]});  // old data
      end else begin
        exp_q[p].push_back('0);
      end
    end
    taken = '0;
    for (int p = 0; p < `MRPW_NUMWRPT; p++) begin
      if (exp_ready && stim_wr[p].write && !taken[stim_wr[p].badr]) begin
        shadow[stim_wr[p].badr][stim_wr[p].radr] = stim_wr[p].din;
        taken[stim_wr[p].badr] = 1'b1;  // later ports lose this bank
      end
    end
    for (int p = 0; p < `MRPW_NUMWRPT; p++) begin
      wr_req[p] = stim_wr[p];
    end
    for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
      rd_req[p] = stim_rd[p];
    end
    set_idle();
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      run_cycle();
    end
  endtask

  initial begin
    int bnk;
    int row;
    rst_n = 1'b0;
    set_idle();
    for (int p = 0; p < `MRPW_NUMWRPT; p++) begin
      wr_req[p] = '0;
    end
    for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
      rd_req[p] = '0;
      for (int s = 0; s < DEPTH; s++) begin
        exp_q[p].push_back('0);
      end
    end
    for (int b = 0; b < `MRPW_NUMVBNK; b++) begin
      for (int r = 0; r < `MRPW_NUMVROW; r++) begin
        shadow[b][r] = '0;
      end
    end
    repeat (5) begin
      @(posedge clk);
      #5;
      check_eq("ready", 0, ready);
      for (int p = 0; p < `MRPW_NUMRDPT; p++) begin
        check_eq($sformatf("rd_rsp[%0d].vld", p), 0, rd_rsp[p].vld);
      end
    end
    rst_n = 1'b1;

    // strobes on every sweep cycle are all masked
    for (int k = 1; k < `MRPW_NUMVROW; k++) begin
      random_stim(1'b1, 1'b1);
      run_cycle();
    end

    // every row reads back zero with port 1 in reverse order
    for (int a = 0; a < `MRPW_NUMVBNK * `MRPW_NUMVROW; a++) begin
      set_read(0, a / `MRPW_NUMVROW, a % `MRPW_NUMVROW);
      set_read(1, (`MRPW_NUMVBNK - 1) - a / `MRPW_NUMVROW,
               (`MRPW_NUMVROW - 1) - a % `MRPW_NUMVROW);
      run_cycle();
    end
    idle_cycles(DEPTH);

    for (int i = 0; i < 4; i++) begin
      bnk = take_bits(`MRPW_BITVBNK);
      row = take_bits(`MRPW_BITVROW);
      set_write(i % `MRPW_NUMWRPT, bnk, row, take_bits(`MRPW_WIDTH));
      run_cycle();
      set_read(0, bnk, row);
      set_read(1, bnk, row);
      run_cycle();
      idle_cycles(DEPTH);  // lone responses pin the latency
    end

    // two writes to different banks and then to one bank
    bnk = take_bits(`MRPW_BITVBNK);
    row = take_bits(`MRPW_BITVROW);
    set_write(0, bnk, row, take_bits(`MRPW_WIDTH));
    set_write(1, (bnk + 1) % `MRPW_NUMVBNK, row, take_bits(`MRPW_WIDTH));
    run_cycle();
    set_read(0, bnk, row);
    set_read(1, (bnk + 1) % `MRPW_NUMVBNK, row);
    run_cycle();
    idle_cycles(DEPTH);
    set_write(0, bnk, row, take_bits(`MRPW_WIDTH));
    set_write(1, bnk, row, take_bits(`MRPW_WIDTH));
    run_cycle();
    set_read(0, bnk, row);
    set_read(1, bnk, row);
    run_cycle();
    idle_cycles(DEPTH);
    set_write(0, bnk, row, take_bits(`MRPW_WIDTH));
    set_write(1, bnk, (row + 1) % `MRPW_NUMVROW, take_bits(`MRPW_WIDTH));
    run_cycle();
    set_read(0, bnk, row);
    set_read(1, bnk, (row + 1) % `MRPW_NUMVROW);
    run_cycle();
    idle_cycles(DEPTH);

    // read and write of one address in the same cycle
    bnk = take_bits(`MRPW_BITVBNK);
    row = take_bits(`MRPW_BITVROW);
    set_write(0, bnk, row, take_bits(`MRPW_WIDTH));
    set_read(0, bnk, row);
    set_read(1, bnk, row);
    run_cycle();
    set_read(0, bnk, row);
    set_read(1, bnk, row);
    run_cycle();
    idle_cycles(DEPTH);

    for (int i = 0; i < RAND_CYC; i++) begin
      random_stim(1'b1, 1'b0);
      run_cycle();
    end
    idle_cycles(DEPTH);

    if (u_dut.u_chk.assert_errs == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("checker assertions failed %0d times", u_dut.u_chk.assert_errs);
      $display("test failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule
